// File: Makefile
# Verilator build and run for the session table testbench.
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_toe_session_table
FILELIST  ?= toe_session_table.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		{ echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_clock_gen.sv
/*
  Clock and reset source for the session table testbench.
  Period is 8 time units. Reset stays low for 8 rising edges and is
  released on a falling edge, clear of the DUT's sampling edge.
*/
`default_nettype none

module tb_clock_gen (
  output logic net_clk,
  output logic net_aresetn
);

  localparam int HALF_PERIOD  = 4;  // 8 unit period
  localparam int RESET_CYCLES = 8;

  initial begin
    net_clk = 1'b0;
    forever #HALF_PERIOD net_clk = ~net_clk;
  end

  initial begin
    net_aresetn = 1'b0;                        // sync reset, held from time 0
    repeat (RESET_CYCLES) @(posedge net_clk);
    @(negedge net_clk);                        // release mid-cycle
    net_aresetn = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/tb_toe_session_table.sv
/*
  Table-driven testbench for the session table.
  Inputs change on the falling edge, responses are sampled on the
  falling edge while their strobe is high. Expected values are worked
  out by hand from the insert/delete/lookup rules. Keys are built so
  that three of them share one bucket; a watchdog bounds the run.
*/
`default_nettype none

module tb_toe_session_table;
  import toe_pkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int NUM_TESTS     = 18;
  localparam int WATCHDOG_TIME = (NUM_TESTS * 10 + 20) * CLK_PERIOD;

  localparam logic [1:0] LOOKUP_ONLY = 2'd0;
  localparam logic [1:0] UPDATE_ONLY = 2'd1;
  localparam logic [1:0] BOTH_PORTS  = 2'd2;  // both strobed in one cycle

  typedef struct packed {
    logic [1:0]              kind;
    upd_op_t                 op;
    logic [KEY_W-1:0]        upd_key;
    logic [SESSION_ID_W-1:0] upd_id;
    logic                    exp_ok;      // update success
    logic [SESSION_ID_W-1:0] exp_upd_id;
    logic [KEY_W-1:0]        lk_key;
    logic                    exp_hit;
    logic [SESSION_ID_W-1:0] exp_lk_id;
    logic [COUNT_W-1:0]      exp_count;   // counters after the test
    logic [COUNT_W-1:0]      exp_fail;
  } entry_t;

  logic                    net_clk, net_aresetn;
  logic                    lup_req_valid;
  logic [KEY_W-1:0]        lup_req_key;
  logic                    lup_rsp_valid, lup_rsp_hit;
  logic [SESSION_ID_W-1:0] lup_rsp_session_id;
  logic                    upd_req_valid;
  upd_op_t                 upd_req_op;
  logic [KEY_W-1:0]        upd_req_key;
  logic [SESSION_ID_W-1:0] upd_req_session_id;
  logic                    upd_rsp_valid, upd_rsp_success;
  logic [SESSION_ID_W-1:0] upd_rsp_session_id;
  logic [COUNT_W-1:0]      session_count, insert_failure_count;

  entry_t           tests [NUM_TESTS];
  int               fill_idx;
  int               error_count;
  logic [KEY_W-1:0] ka, kb, kc, kd, ke;  // ka to kc share bucket 3

  tb_clock_gen u_clk (.net_clk, .net_aresetn);

  toe_session_table dut (
    .net_clk, .net_aresetn,
    .lup_req_valid, .lup_req_key,
    .lup_rsp_valid, .lup_rsp_hit, .lup_rsp_session_id,
    .upd_req_valid, .upd_req_op, .upd_req_key, .upd_req_session_id,
    .upd_rsp_valid, .upd_rsp_success, .upd_rsp_session_id,
    .session_count, .insert_failure_count
  );

  // low 3 key bits feed hash lanes 0..2 directly so xor steers the bucket
  function automatic logic [KEY_W-1:0] place_key(input logic [KEY_W-1:0] base,
                                                 input logic [BUCKET_W-1:0] bucket);
    logic [KEY_W-1:0] k;
    k = base;
    k[BUCKET_W-1:0] = k[BUCKET_W-1:0] ^ key_hash(base) ^ bucket;
    return k;
  endfunction

  task automatic add_entry(input logic [1:0] kind, input upd_op_t op,
                           input logic [KEY_W-1:0] ukey, input logic [SESSION_ID_W-1:0] uid,
                           input logic ok, input logic [SESSION_ID_W-1:0] oid,
                           input logic [KEY_W-1:0] lkey, input logic hit,
                           input logic [SESSION_ID_W-1:0] lid, input int cnt, input int fail);
    tests[fill_idx] = '{kind, op, ukey, uid, ok, oid, lkey, hit, lid,
                        COUNT_W'(cnt), COUNT_W'(fail)};
    fill_idx++;
  endtask

  task automatic fill_table();
    ka = place_key({32'h0a00_0001, 16'hc350, 16'h0050}, 3'd3);  // {ip, rport, lport}
    kb = place_key({32'h0a00_0002, 16'hc351, 16'h0050}, 3'd3);
    kc = place_key({32'h0a00_0003, 16'hc352, 16'h0050}, 3'd3);
    kd = place_key({32'hc0a8_0107, 16'hd431, 16'h01bb}, 3'd5);
    ke = place_key({32'hac10_0009, 16'he001, 16'h0016}, 3'd6);
    fill_idx = 0;
    add_entry(LOOKUP_ONLY, OP_INSERT, '0, '0, 1'b0, '0, ka, 1'b0, 16'h0, 0, 0);  // empty table
    add_entry(UPDATE_ONLY, OP_INSERT, ka, 16'h0101, 1'b1, 16'h0101, '0, 1'b0, '0, 1, 0);
    add_entry(LOOKUP_ONLY, OP_INSERT, '0, '0, 1'b0, '0, ka, 1'b1, 16'h0101, 1, 0);
    add_entry(UPDATE_ONLY, OP_INSERT, kb, 16'h0202, 1'b1, 16'h0202, '0, 1'b0, '0, 2, 0);
    add_entry(UPDATE_ONLY, OP_INSERT, kc, 16'h0303, 1'b0, 16'h0, '0, 1'b0, '0, 2, 1);  // full
    add_entry(LOOKUP_ONLY, OP_INSERT, '0, '0, 1'b0, '0, kc, 1'b0, 16'h0, 2, 1);
    add_entry(LOOKUP_ONLY, OP_INSERT, '0, '0, 1'b0, '0, kb, 1'b1, 16'h0202, 2, 1);
    add_entry(UPDATE_ONLY, OP_INSERT, ka, 16'h0999, 1'b1, 16'h0101, '0, 1'b0, '0, 2, 1);  // dup
    add_entry(LOOKUP_ONLY, OP_INSERT, '0, '0, 1'b0, '0, ka, 1'b1, 16'h0101, 2, 1);
    add_entry(UPDATE_ONLY, OP_DELETE, ka, '0, 1'b1, 16'h0101, '0, 1'b0, '0, 1, 1);
    add_entry(LOOKUP_ONLY, OP_INSERT, '0, '0, 1'b0, '0, ka, 1'b0, 16'h0, 1, 1);
    add_entry(UPDATE_ONLY, OP_DELETE, ka, '0, 1'b0, 16'h0, '0, 1'b0, '0, 1, 1);  // absent
    add_entry(UPDATE_ONLY, OP_INSERT, kc, 16'h0303, 1'b1, 16'h0303, '0, 1'b0, '0, 2, 1);
    // previous grant was an update so the lookup goes first here
    add_entry(BOTH_PORTS, OP_INSERT, kd, 16'h0404, 1'b1, 16'h0404, kb, 1'b1, 16'h0202, 3, 1);
    add_entry(LOOKUP_ONLY, OP_INSERT, '0, '0, 1'b0, '0, kc, 1'b1, 16'h0303, 3, 1);
    add_entry(BOTH_PORTS, OP_DELETE, kb, '0, 1'b1, 16'h0202, kd, 1'b1, 16'h0404, 2, 1);
    add_entry(BOTH_PORTS, OP_INSERT, ke, 16'h0505, 1'b1, 16'h0505, kc, 1'b1, 16'h0303, 3, 1);
    add_entry(LOOKUP_ONLY, OP_INSERT, '0, '0, 1'b0, '0, kb, 1'b0, 16'h0, 3, 1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
      error_count++;
    end
  endtask

  task automatic run_entry(input int n);
    entry_t e;
    logic   want_lk, want_up, got_lk, got_up;
    int     errs_before;
    e           = tests[n];
    errs_before = error_count;
    want_lk     = (e.kind != UPDATE_ONLY);
    want_up     = (e.kind != LOOKUP_ONLY);
    got_lk      = 1'b0;
    got_up      = 1'b0;
    @(negedge net_clk);
    lup_req_valid      = want_lk;  // single-cycle strobes
    lup_req_key        = e.lk_key;
    upd_req_valid      = want_up;
    upd_req_op         = e.op;
    upd_req_key        = e.upd_key;
    upd_req_session_id = e.upd_id;
    @(negedge net_clk);
    lup_req_valid = 1'b0;
    upd_req_valid = 1'b0;
    while ((want_lk && !got_lk) || (want_up && !got_up)) begin  // watchdog bounds this
      if (lup_rsp_valid && !got_lk) begin
        got_lk = 1'b1;
        assert (want_lk) else begin
          $display("test %0d: lookup response arrived with no lookup issued", n);
          error_count++;
        end
        check_value("lup_rsp_hit", lup_rsp_hit, e.exp_hit);
        check_value("lup_rsp_session_id", lup_rsp_session_id, e.exp_lk_id);
      end
      if (upd_rsp_valid && !got_up) begin
        got_up = 1'b1;
        assert (want_up) else begin
          $display("test %0d: update response arrived with no update issued", n);
          error_count++;
        end
        check_value("upd_rsp_success", upd_rsp_success, e.exp_ok);
        check_value("upd_rsp_session_id", upd_rsp_session_id, e.exp_upd_id);
      end
      if ((want_lk && !got_lk) || (want_up && !got_up)) @(negedge net_clk);
    end
    check_value("session_count", session_count, e.exp_count);  // already updated by now
    check_value("insert_failure_count", insert_failure_count, e.exp_fail);
    $display("test %0d kind %0d: %s", n, e.kind, (error_count == errs_before) ? "ok" : "FAILED");
  endtask

  initial begin
    lup_req_valid      = 1'b0;
    lup_req_key        = '0;
    upd_req_valid      = 1'b0;
    upd_req_op         = OP_INSERT;
    upd_req_key        = '0;
    upd_req_session_id = '0;
    error_count        = 0;
    fill_table();
    wait (net_aresetn === 1'b1);
    @(negedge net_clk);
    check_value("lup_rsp_valid", lup_rsp_valid, 1'b0);  // post-reset state
    check_value("upd_rsp_valid", upd_rsp_valid, 1'b0);
    check_value("session_count", session_count, '0);
    check_value("insert_failure_count", insert_failure_count, '0);
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_entry(i);
    end
    $display("tests run %0d, errors %0d", NUM_TESTS, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // bounds the run if a response never shows
  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: the DUT stopped responding before all %0d tests were done", NUM_TESTS);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/bucket_ram.sv
/*
  Single-port bucket store, one bucket per address.
  Read data shows one cycle after the address, old contents on a
  same-cycle write. A write replaces all ways of the bucket at once.
  Only the valid bits come out of reset; keys and IDs power up unknown.
*/
`default_nettype none

module bucket_ram (
  input  logic                                                net_clk,
  input  logic                                                net_aresetn,
  input  logic [toe_pkg::BUCKET_W-1:0]                        ram_addr,
  input  logic                                                ram_we,
  input  logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::KEY_W-1:0]        ram_wkeys,
  input  logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::SESSION_ID_W-1:0] ram_wids,
  input  logic [toe_pkg::WAY_COUNT-1:0]                       ram_wvalid,
  output logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::KEY_W-1:0]        ram_rkeys,
  output logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::SESSION_ID_W-1:0] ram_rids,
  output logic [toe_pkg::WAY_COUNT-1:0]                       ram_rvalid
);
  import toe_pkg::*;

  logic [WAY_COUNT-1:0][KEY_W-1:0]        key_mem [BUCKET_COUNT];  // payload arrays
  logic [WAY_COUNT-1:0][SESSION_ID_W-1:0] id_mem  [BUCKET_COUNT];
  logic [BUCKET_COUNT-1:0][WAY_COUNT-1:0] valid_q;                 // per-way occupancy

  // payload side, plain ram
  always_ff @(posedge net_clk) begin
    if (ram_we) begin
      key_mem[ram_addr] <= ram_wkeys;
      id_mem[ram_addr]  <= ram_wids;
    end
    ram_rkeys <= key_mem[ram_addr];  // read-before-write
    ram_rids  <= id_mem[ram_addr];
  end

  // occupancy side, flops so reset empties the table
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      valid_q    <= '0;
      ram_rvalid <= '0;
    end else begin
      if (ram_we) begin
        valid_q[ram_addr] <= ram_wvalid;
      end
      ram_rvalid <= valid_q[ram_addr];  // aligned with key/id read
    end
  end

endmodule

`default_nettype wire

// File: design/session_lookup.sv
/*
  Lookup engine, one request in flight.
  Key is latched on lup_req_valid, port requested from the next cycle
  until granted, response strobed the cycle after the grant.
  Uncontended latency is 2 cycles; an update holding the port stretches
  it to 5. Response fields are combinational off the ram outputs.
*/
`default_nettype none

module session_lookup (
  input  logic                                                net_clk,
  input  logic                                                net_aresetn,
  input  logic                                                lup_req_valid,
  input  logic [toe_pkg::KEY_W-1:0]                           lup_req_key,
  input  logic                                                lk_grant,
  input  logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::KEY_W-1:0]        ram_rkeys,
  input  logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::SESSION_ID_W-1:0] ram_rids,
  input  logic [toe_pkg::WAY_COUNT-1:0]                       ram_rvalid,
  output logic                                                lk_req,
  output logic [toe_pkg::BUCKET_W-1:0]                        lk_addr,
  output logic                                                lup_rsp_valid,
  output logic                                                lup_rsp_hit,
  output logic [toe_pkg::SESSION_ID_W-1:0]                    lup_rsp_session_id
);
  import toe_pkg::*;

  logic [KEY_W-1:0]     key_q;   // held till response
  logic                 pend_q;  // waiting for grant
  logic                 rd_q;    // bucket data valid this cycle
  logic [WAY_COUNT-1:0] match;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      pend_q <= 1'b0;
      rd_q   <= 1'b0;
    end else begin
      if (lup_req_valid) begin
        pend_q <= 1'b1;
      end else if (lk_grant) begin
        pend_q <= 1'b0;
      end
      rd_q <= lk_grant;  // ram answers next cycle
    end
  end

  always_ff @(posedge net_clk) begin
    if (lup_req_valid) begin
      key_q <= lup_req_key;
    end
  end

  assign lk_req  = pend_q;
  assign lk_addr = key_hash(key_q);

  // compare both ways, at most one can match
  always_comb begin
    lup_rsp_session_id = '0;  // miss returns zero
    for (int w = 0; w < WAY_COUNT; w++) begin
      match[w] = ram_rvalid[w] && (ram_rkeys[w] == key_q);
      if (match[w]) begin
        lup_rsp_session_id = ram_rids[w];
      end
    end
  end

  assign lup_rsp_valid = rd_q;
  assign lup_rsp_hit   = |match;

  // one outstanding request per port
  a_no_overlap: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    lup_req_valid |-> !(pend_q || rd_q));

endmodule

`default_nettype wire

// File: design/session_update.sv
/*
  Insert/delete engine, one request in flight.
  Read-modify-write of a whole bucket: wait for port, read, then write
  back and respond. Port stays requested across read and write so the
  arbiter keeps it locked. Response 3 cycles after request, 4 if a
  lookup wins the port first.
  Counters saturate only by construction; a full table fails inserts.
*/
`default_nettype none

module session_update (
  input  logic                                                net_clk,
  input  logic                                                net_aresetn,
  input  logic                                                upd_req_valid,
  input  toe_pkg::upd_op_t                                    upd_req_op,
  input  logic [toe_pkg::KEY_W-1:0]                           upd_req_key,
  input  logic [toe_pkg::SESSION_ID_W-1:0]                    upd_req_session_id,
  input  logic                                                up_grant,
  input  logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::KEY_W-1:0]        ram_rkeys,
  input  logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::SESSION_ID_W-1:0] ram_rids,
  input  logic [toe_pkg::WAY_COUNT-1:0]                       ram_rvalid,
  output logic                                                up_req,
  output logic [toe_pkg::BUCKET_W-1:0]                        up_addr,
  output logic                                                up_we,
  output logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::KEY_W-1:0]        up_wkeys,
  output logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::SESSION_ID_W-1:0] up_wids,
  output logic [toe_pkg::WAY_COUNT-1:0]                       up_wvalid,
  output logic                                                upd_rsp_valid,
  output logic                                                upd_rsp_success,
  output logic [toe_pkg::SESSION_ID_W-1:0]                    upd_rsp_session_id,
  output logic [toe_pkg::COUNT_W-1:0]                         session_count,
  output logic [toe_pkg::COUNT_W-1:0]                         insert_failure_count
);
  import toe_pkg::*;

  logic [UPD_ST_W-1:0]     state_q;
  upd_op_t                 op_q;
  logic [KEY_W-1:0]        key_q;
  logic [SESSION_ID_W-1:0] id_q;
  logic                    we_q, succ_q;
  logic [SESSION_ID_W-1:0] rsp_id_q;
  logic                    hit, free;
  logic [WAY_W-1:0]        hit_way, free_way;
  logic [SESSION_ID_W-1:0] hit_id;
  logic                    do_ins, do_del, ins_fail;

  // scan bucket, lowest free way wins
  always_comb begin
    hit = 1'b0; hit_way = '0; hit_id = '0;
    free = 1'b0; free_way = '0;
    for (int w = WAY_COUNT - 1; w >= 0; w--) begin
      if (ram_rvalid[w] && (ram_rkeys[w] == key_q)) begin
        hit = 1'b1; hit_way = WAY_W'(w); hit_id = ram_rids[w];
      end
      if (!ram_rvalid[w]) begin
        free = 1'b1; free_way = WAY_W'(w);
      end
    end
  end

  assign do_ins   = (op_q == OP_INSERT) && !hit && free;   // new entry
  assign ins_fail = (op_q == OP_INSERT) && !hit && !free;  // bucket full
  assign do_del   = (op_q == OP_DELETE) && hit;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      state_q <= UPD_ST_IDLE;
      we_q <= 1'b0; succ_q <= 1'b0;
      session_count <= '0; insert_failure_count <= '0;
    end else begin
      case (state_q)
        UPD_ST_IDLE:  if (upd_req_valid) state_q <= UPD_ST_WAIT;
        UPD_ST_WAIT:  if (up_grant) state_q <= UPD_ST_READ;
        UPD_ST_READ: begin
          state_q <= UPD_ST_WRITE;
          we_q    <= do_ins || do_del;
          succ_q  <= hit || do_ins;  // existing key counts as success on insert
          if (do_ins) session_count <= session_count + 1'b1;
          if (do_del) session_count <= session_count - 1'b1;
          if (ins_fail) insert_failure_count <= insert_failure_count + 1'b1;
        end
        default:      state_q <= UPD_ST_IDLE;  // write slot, done
      endcase
    end
  end

  // request payload and write-back bucket
  always_ff @(posedge net_clk) begin
    if (upd_req_valid) begin
      op_q <= upd_req_op; key_q <= upd_req_key; id_q <= upd_req_session_id;
    end
    if (state_q == UPD_ST_READ) begin
      up_wkeys <= ram_rkeys; up_wids <= ram_rids; up_wvalid <= ram_rvalid;
      rsp_id_q <= hit ? hit_id : '0;  // stored id for dup insert or delete
      if (do_ins) begin
        up_wkeys[free_way]  <= key_q;
        up_wids[free_way]   <= id_q;
        up_wvalid[free_way] <= 1'b1;
        rsp_id_q            <= id_q;
      end
      if (do_del) up_wvalid[hit_way] <= 1'b0;  // key and id left stale
    end
  end

  assign up_req             = (state_q != UPD_ST_IDLE);  // held through write
  assign up_addr            = key_hash(key_q);
  assign up_we              = (state_q == UPD_ST_WRITE) && we_q;
  assign upd_rsp_valid      = (state_q == UPD_ST_WRITE);
  assign upd_rsp_success    = succ_q;
  assign upd_rsp_session_id = rsp_id_q;

  a_no_overlap: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    upd_req_valid |-> state_q == UPD_ST_IDLE);

  a_count_max: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    session_count <= COUNT_W'(BUCKET_COUNT * WAY_COUNT));

endmodule

`default_nettype wire

// File: design/table_arbiter.sv
/*
  Shares the one bucket port between lookup and update engines.
  Grant is combinational, same cycle as the request.
  Once the update engine is granted it keeps the port until up_req
  drops, so its read and write of a bucket are never split by a lookup.
  Contention from idle goes to whichever engine was not served last.
*/
`default_nettype none

module table_arbiter (
  input  logic                                                net_clk,
  input  logic                                                net_aresetn,
  input  logic                                                lk_req,
  input  logic [toe_pkg::BUCKET_W-1:0]                        lk_addr,
  input  logic                                                up_req,
  input  logic [toe_pkg::BUCKET_W-1:0]                        up_addr,
  input  logic                                                up_we,
  input  logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::KEY_W-1:0]        up_wkeys,
  input  logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::SESSION_ID_W-1:0] up_wids,
  input  logic [toe_pkg::WAY_COUNT-1:0]                       up_wvalid,
  output logic                                                lk_grant,
  output logic                                                up_grant,
  output logic [toe_pkg::BUCKET_W-1:0]                        ram_addr,
  output logic                                                ram_we,
  output logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::KEY_W-1:0]        ram_wkeys,
  output logic [toe_pkg::WAY_COUNT-1:0][toe_pkg::SESSION_ID_W-1:0] ram_wids,
  output logic [toe_pkg::WAY_COUNT-1:0]                       ram_wvalid
);

  logic lock_q;     // update owns the port
  logic last_up_q;  // last grant went to update

  always_comb begin
    lk_grant = 1'b0;
    up_grant = 1'b0;
    if (lock_q && up_req) begin
      up_grant = 1'b1;          // rmw in progress
    end else if (lk_req && up_req) begin
      lk_grant = last_up_q;     // round robin
      up_grant = !last_up_q;
    end else begin
      lk_grant = lk_req;
      up_grant = up_req;
    end
  end

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      lock_q    <= 1'b0;
      last_up_q <= 1'b0;
    end else begin
      lock_q <= up_grant;       // falls with up_req
      if (lk_grant || up_grant) begin
        last_up_q <= up_grant;
      end
    end
  end

  // port mux where only update ever writes
  assign ram_addr   = up_grant ? up_addr : lk_addr;
  assign ram_we     = up_grant && up_we;
  assign ram_wkeys  = up_wkeys;
  assign ram_wids   = up_wids;
  assign ram_wvalid = up_wvalid;

  a_one_grant: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    !(lk_grant && up_grant));

endmodule

`default_nettype wire

// File: design/toe_pkg.sv
/*
  Shared sizes and helpers for the session table.
  Table is small: 8 buckets of 2 ways, so at most 16 live sessions.
  Keys carry remote IP, remote port and local port packed into 64 bits.
  key_hash is a plain XOR fold with no mixing, so keys differing only in
  bits that cancel across 3-bit slices collide on purpose.
*/
`default_nettype none

package toe_pkg;

  // table geometry
  localparam int KEY_W        = 64;   // {remote ip, remote port, local port}
  localparam int SESSION_ID_W = 16;
  localparam int BUCKET_W     = 3;
  localparam int BUCKET_COUNT = 8;    // 2**BUCKET_W
  localparam int WAY_COUNT    = 2;
  localparam int WAY_W        = 1;    // index into ways
  localparam int COUNT_W      = 16;   // session and failure counters

  // update engine states
  localparam int              UPD_ST_W     = 2;
  localparam [UPD_ST_W-1:0]   UPD_ST_IDLE  = 2'd0;
  localparam [UPD_ST_W-1:0]   UPD_ST_WAIT  = 2'd1;  // asking for the port
  localparam [UPD_ST_W-1:0]   UPD_ST_READ  = 2'd2;  // bucket data on rdata
  localparam [UPD_ST_W-1:0]   UPD_ST_WRITE = 2'd3;  // write back + respond

  typedef enum logic {
    OP_INSERT = 1'b0,
    OP_DELETE = 1'b1
  } upd_op_t;

  // fold key into bucket index, xor of 3-bit slices
  // top slice is short (64 = 21*3 + 1), upper bits read as zero
  function automatic logic [BUCKET_W-1:0] key_hash(input logic [KEY_W-1:0] key);
    logic [BUCKET_W-1:0] h;
    h = '0;
    for (int i = 0; i < KEY_W; i++) begin
      h[i % BUCKET_W] ^= key[i];  // bit i lands in slice lane i mod 3
    end
    return h;
  endfunction

endpackage

`default_nettype wire

// File: design/toe_session_table.sv
/*
  Session lookup table of the offload engine.
  Strobe interfaces, no back-pressure: responses must be taken when
  strobed. One request outstanding per port; lookup and update ports
  run independently and may overlap. Counters are plain levels.
*/
`default_nettype none

module toe_session_table (
  input  logic                                 net_clk,
  input  logic                                 net_aresetn,
  input  logic                                 lup_req_valid,
  input  logic [toe_pkg::KEY_W-1:0]            lup_req_key,
  output logic                                 lup_rsp_valid,
  output logic                                 lup_rsp_hit,
  output logic [toe_pkg::SESSION_ID_W-1:0]     lup_rsp_session_id,
  input  logic                                 upd_req_valid,
  input  toe_pkg::upd_op_t                     upd_req_op,
  input  logic [toe_pkg::KEY_W-1:0]            upd_req_key,
  input  logic [toe_pkg::SESSION_ID_W-1:0]     upd_req_session_id,
  output logic                                 upd_rsp_valid,
  output logic                                 upd_rsp_success,
  output logic [toe_pkg::SESSION_ID_W-1:0]     upd_rsp_session_id,
  output logic [toe_pkg::COUNT_W-1:0]          session_count,
  output logic [toe_pkg::COUNT_W-1:0]          insert_failure_count
);
  import toe_pkg::*;

  logic                                   lk_req, lk_grant, up_req, up_grant, up_we, ram_we;
  logic [BUCKET_W-1:0]                    lk_addr, up_addr, ram_addr;
  logic [WAY_COUNT-1:0][KEY_W-1:0]        up_wkeys, ram_wkeys, ram_rkeys;
  logic [WAY_COUNT-1:0][SESSION_ID_W-1:0] up_wids, ram_wids, ram_rids;
  logic [WAY_COUNT-1:0]                   up_wvalid, ram_wvalid, ram_rvalid;

  session_lookup u_lookup (
    .net_clk, .net_aresetn,
    .lup_req_valid, .lup_req_key,
    .lk_grant, .ram_rkeys, .ram_rids, .ram_rvalid,   // read side shared
    .lk_req, .lk_addr,
    .lup_rsp_valid, .lup_rsp_hit, .lup_rsp_session_id
  );

  session_update u_update (
    .net_clk, .net_aresetn,
    .upd_req_valid, .upd_req_op, .upd_req_key, .upd_req_session_id,
    .up_grant, .ram_rkeys, .ram_rids, .ram_rvalid,
    .up_req, .up_addr, .up_we, .up_wkeys, .up_wids, .up_wvalid,
    .upd_rsp_valid, .upd_rsp_success, .upd_rsp_session_id,
    .session_count, .insert_failure_count
  );

  table_arbiter u_arbiter (
    .net_clk, .net_aresetn,
    .lk_req, .lk_addr,
    .up_req, .up_addr, .up_we, .up_wkeys, .up_wids, .up_wvalid,
    .lk_grant, .up_grant,
    .ram_addr, .ram_we, .ram_wkeys, .ram_wids, .ram_wvalid
  );

  bucket_ram u_ram (
    .net_clk, .net_aresetn,
    .ram_addr, .ram_we, .ram_wkeys, .ram_wids, .ram_wvalid,
    .ram_rkeys, .ram_rids, .ram_rvalid
  );

endmodule

`default_nettype wire

// File: toe_session_table.f
design/toe_pkg.sv
design/bucket_ram.sv
design/table_arbiter.sv
design/session_lookup.sv
design/session_update.sv
design/toe_session_table.sv
bench/tb_clock_gen.sv
bench/tb_toe_session_table.sv
